// ==== verilog/rs_cfg_pkg.sv ====
`default_nettype none

package rs_cfg_pkg;

    // station geometry
    localparam int RS_DEPTH = 8;
    localparam int RS_IDX_W = 3;    // log2 of RS_DEPTH

    // physical register file
    localparam int TAG_W    = 8;
    localparam int DATA_W   = 32;

    // front end
    localparam int PC_W     = 32;

    // ALU, MUL and load return
    localparam int NUM_CDB  = 3;

endpackage

`default_nettype wire

// ==== verilog/rs_types_pkg.sv ====
`default_nettype none

package rs_types_pkg;
    import rs_cfg_pkg::*;

    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [PC_W-1:0]     pc_t;
    typedef logic [RS_IDX_W-1:0] rs_idx_t;

    // bus position in the broadcast array
    typedef enum logic [1:0] {
        CDB_ALU,
        CDB_MUL,
        CDB_LOAD
    } cdb_src_e;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        data_t data;
    } cdb_t;

    typedef cdb_t [NUM_CDB-1:0] cdb_vec_t;

    typedef struct packed {
        tag_t  tag;
        data_t data;
        logic  valid;
    } operand_t;

    typedef struct packed {
        pc_t      pc;
        tag_t     rd;
        operand_t src1;
        operand_t src2;
    } rs_entry_t;

    typedef enum logic [1:0] {
        ENTRY_EMPTY,
        ENTRY_WAIT,
        ENTRY_READY
    } entry_state_e;

    typedef struct packed {
        pc_t   pc;
        tag_t  rd;
        data_t src1;
        data_t src2;
    } issue_t;

    // fill a waiting operand from any valid bus carrying its tag
    function automatic operand_t snoop_operand(operand_t op, cdb_vec_t bus);
        operand_t res;
        res = op;
        for (int b = 0; b < NUM_CDB; b++) begin
            if (!op.valid && bus[b].valid && bus[b].tag == op.tag) begin
                res.data  = bus[b].data;
                res.valid = 1'b1;
            end
        end
        return res;
    endfunction

endpackage

`default_nettype wire

// ==== verilog/rs_ifs.sv ====
`default_nettype none

// result broadcast, one slot per cdb_src_e
interface cdb_if;
    import rs_types_pkg::*;

    cdb_vec_t bus;

    modport snoop (
        input bus
    );
endinterface

interface rs_write_if;
    import rs_types_pkg::*;

    logic      wr_en;    // one pulse per dispatch
    rs_idx_t   wr_idx;
    rs_entry_t wr_entry;

    modport source (
        output wr_en,
        output wr_idx,
        output wr_entry
    );

    modport sink (
        input wr_en,
        input wr_idx,
        input wr_entry
    );
endinterface

interface rs_select_if;
    import rs_cfg_pkg::*;
    import rs_types_pkg::*;

    logic [RS_DEPTH-1:0]      ready_vec;
    rs_entry_t [RS_DEPTH-1:0] entries;
    logic                     grant_en;
    rs_idx_t                  grant_idx;   // slot freed at next edge

    modport array (
        output ready_vec,
        output entries,
        input  grant_en,
        input  grant_idx
    );

    modport picker (
        input  ready_vec,
        input  entries,
        output grant_en,
        output grant_idx
    );
endinterface

`default_nettype wire

// ==== verilog/rs_dispatch.sv ====
`default_nettype none

module rs_dispatch (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   disp_valid,
    input  rs_types_pkg::pc_t      disp_pc,
    input  rs_types_pkg::tag_t     disp_rd,
    input  rs_types_pkg::operand_t disp_src1,
    input  rs_types_pkg::operand_t disp_src2,
    cdb_if.snoop                   cdb,
    rs_write_if.source             wr
);
    import rs_cfg_pkg::*;
    import rs_types_pkg::*;

    rs_idx_t  tail;
    operand_t src1_cap;
    operand_t src2_cap;

    // round robin slot pointer, no full check
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tail <= '0;
        end else if (disp_valid) begin
            tail <= tail + 1'b1;   // wraps at RS_DEPTH
        end
    end

    // bypass from a bus broadcasting in the dispatch cycle
    always_comb begin
        src1_cap = snoop_operand(disp_src1, cdb.bus);
        src2_cap = snoop_operand(disp_src2, cdb.bus);
    end

    always_comb begin
        wr.wr_en         = disp_valid;
        wr.wr_idx        = tail;
        wr.wr_entry.pc   = disp_pc;
        wr.wr_entry.rd   = disp_rd;
        wr.wr_entry.src1 = src1_cap;
        wr.wr_entry.src2 = src2_cap;
    end

endmodule

`default_nettype wire

// ==== verilog/rs_entry_array.sv ====
`default_nettype none

module rs_entry_array (
    input  logic       clk,
    input  logic       reset,
    rs_write_if.sink   wr,
    cdb_if.snoop       cdb,
    rs_select_if.array sel
);
    import rs_cfg_pkg::*;
    import rs_types_pkg::*;

    rs_entry_t [RS_DEPTH-1:0] entries;
    rs_entry_t [RS_DEPTH-1:0] woken;       // entries after this cycle's snoop
    entry_state_e             state [RS_DEPTH];

    // wakeup, every cycle
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            woken[i]      = entries[i];
            woken[i].src1 = snoop_operand(entries[i].src1, cdb.bus);
            woken[i].src2 = snoop_operand(entries[i].src2, cdb.bus);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                state[i] <= ENTRY_EMPTY;
            end
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (wr.wr_en && wr.wr_idx == rs_idx_t'(i)) begin
                    if (wr.wr_entry.src1.valid && wr.wr_entry.src2.valid) begin
                        state[i] <= ENTRY_READY;
                    end else begin
                        state[i] <= ENTRY_WAIT;
                    end
                end else if (sel.grant_en && sel.grant_idx == rs_idx_t'(i)) begin
                    state[i] <= ENTRY_EMPTY;
                end else if (state[i] == ENTRY_WAIT &&
                             woken[i].src1.valid && woken[i].src2.valid) begin
                    state[i] <= ENTRY_READY;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (wr.wr_en && wr.wr_idx == rs_idx_t'(i)) begin
                entries[i] <= wr.wr_entry;
            end else if (state[i] == ENTRY_WAIT) begin
                entries[i] <= woken[i];   // only waiting slots take bus data
            end
        end
    end

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            sel.ready_vec[i] = (state[i] == ENTRY_READY);
        end
    end

    assign sel.entries = entries;

endmodule

`default_nettype wire

// ==== verilog/rs_issue_select.sv ====
`default_nettype none

module rs_issue_select (
    input  logic                 clk,
    input  logic                 reset,
    rs_select_if.picker          sel,
    output rs_types_pkg::issue_t issue,
    output logic                 issue_valid
);
    import rs_cfg_pkg::*;
    import rs_types_pkg::*;

    rs_entry_t picked;

    // lowest index wins, scanned from the top down
    always_comb begin
        sel.grant_en  = 1'b0;
        sel.grant_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (sel.ready_vec[i]) begin
                sel.grant_en  = 1'b1;
                sel.grant_idx = rs_idx_t'(i);
            end
        end
    end

    assign picked = sel.entries[sel.grant_idx];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= sel.grant_en;
        end
    end

    always_ff @(posedge clk) begin
        if (sel.grant_en) begin
            issue.pc   <= picked.pc;
            issue.rd   <= picked.rd;
            issue.src1 <= picked.src1.data;
            issue.src2 <= picked.src2.data;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rs_mul_top.sv ====
`default_nettype none

module rs_mul_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            disp_valid,
    input  logic [rs_cfg_pkg::PC_W-1:0]     disp_pc,
    input  logic [rs_cfg_pkg::TAG_W-1:0]    disp_rd,
    input  logic [rs_cfg_pkg::TAG_W-1:0]    disp_src1_tag,
    input  logic [rs_cfg_pkg::DATA_W-1:0]   disp_src1_data,
    input  logic                            disp_src1_valid,
    input  logic [rs_cfg_pkg::TAG_W-1:0]    disp_src2_tag,
    input  logic [rs_cfg_pkg::DATA_W-1:0]   disp_src2_data,
    input  logic                            disp_src2_valid,
    input  logic                            alu_valid,
    input  logic [rs_cfg_pkg::TAG_W-1:0]    alu_tag,
    input  logic [rs_cfg_pkg::DATA_W-1:0]   alu_data,
    input  logic                            mul_valid,
    input  logic [rs_cfg_pkg::TAG_W-1:0]    mul_tag,
    input  logic [rs_cfg_pkg::DATA_W-1:0]   mul_data,
    input  logic                            load_valid,
    input  logic [rs_cfg_pkg::TAG_W-1:0]    load_tag,
    input  logic [rs_cfg_pkg::DATA_W-1:0]   load_data,
    output logic                            issue_valid,
    output logic [rs_cfg_pkg::PC_W-1:0]     issue_pc,
    output logic [rs_cfg_pkg::TAG_W-1:0]    issue_rd,
    output logic [rs_cfg_pkg::DATA_W-1:0]   issue_src1,
    output logic [rs_cfg_pkg::DATA_W-1:0]   issue_src2
);
    import rs_types_pkg::*;

    operand_t src1_op;
    operand_t src2_op;
    issue_t   issue;

    cdb_if       cdb_bus ();
    rs_write_if  wr_bus ();
    rs_select_if sel_bus ();

    assign src1_op = '{tag: disp_src1_tag, data: disp_src1_data, valid: disp_src1_valid};
    assign src2_op = '{tag: disp_src2_tag, data: disp_src2_data, valid: disp_src2_valid};

    assign cdb_bus.bus[CDB_ALU]  = '{valid: alu_valid, tag: alu_tag, data: alu_data};
    assign cdb_bus.bus[CDB_MUL]  = '{valid: mul_valid, tag: mul_tag, data: mul_data};
    assign cdb_bus.bus[CDB_LOAD] = '{valid: load_valid, tag: load_tag, data: load_data};

    rs_dispatch u_rs_dispatch (
        .clk        (clk),
        .reset      (reset),
        .disp_valid (disp_valid),
        .disp_pc    (disp_pc),
        .disp_rd    (disp_rd),
        .disp_src1  (src1_op),
        .disp_src2  (src2_op),
        .cdb        (cdb_bus.snoop),
        .wr         (wr_bus.source)
    );

    rs_entry_array u_rs_entry_array (
        .clk   (clk),
        .reset (reset),
        .wr    (wr_bus.sink),
        .cdb   (cdb_bus.snoop),
        .sel   (sel_bus.array)
    );

    rs_issue_select u_rs_issue_select (
        .clk         (clk),
        .reset       (reset),
        .sel         (sel_bus.picker),
        .issue       (issue),
        .issue_valid (issue_valid)
    );

    assign issue_pc   = issue.pc;
    assign issue_rd   = issue.rd;
    assign issue_src1 = issue.src1;
    assign issue_src2 = issue.src2;

endmodule

`default_nettype wire

// ==== bench/rs_mul_assert.sv ====
`default_nettype none

module rs_mul_assert (
    input logic                                          clk,
    input logic                                          reset,
    input logic                                          wr_en,
    input rs_types_pkg::rs_idx_t                         wr_idx,
    input rs_types_pkg::entry_state_e                    state [rs_cfg_pkg::RS_DEPTH],
    input rs_types_pkg::rs_entry_t [rs_cfg_pkg::RS_DEPTH-1:0] entries,
    input logic                                          grant_en,
    input rs_types_pkg::rs_idx_t                         grant_idx
);
    timeunit 1ns;
    timeprecision 1ps;

    import rs_types_pkg::*;

    int fails = 0;   // read by the testbench at the end

    // at most eight outstanding, so the tail never lands on a live slot
    slot_free: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> state[wr_idx] == ENTRY_EMPTY)
        else begin
            fails++;
            $error("dispatch into occupied slot %0d", wr_idx);
        end

    // granted slot must hold both operands
    grant_ready: assert property (@(posedge clk) disable iff (reset)
        grant_en |-> entries[grant_idx].src1.valid && entries[grant_idx].src2.valid)
        else begin
            fails++;
            $error("grant to slot %0d with an operand still missing", grant_idx);
        end

    no_grant_in_reset: assert property (@(posedge clk) reset |-> !grant_en)
        else begin
            fails++;
            $error("grant while reset is active");
        end

endmodule

bind rs_entry_array rs_mul_assert u_rs_mul_assert (
    .clk       (clk),
    .reset     (reset),
    .wr_en     (wr.wr_en),
    .wr_idx    (wr.wr_idx),
    .state     (state),
    .entries   (entries),
    .grant_en  (sel.grant_en),
    .grant_idx (sel.grant_idx)
);

`default_nettype wire

// ==== bench/rs_mul_tb.sv ====
`default_nettype none

module rs_mul_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import rs_cfg_pkg::*;
    import rs_types_pkg::*;

    localparam int MAX_CYCLES = 400;   // six tests, each under 60 cycles

    logic        clk;
    logic        reset;
    logic        disp_valid;
    pc_t         disp_pc;
    tag_t        disp_rd;
    operand_t    disp_src1;
    operand_t    disp_src2;
    cdb_t        alu;
    cdb_t        mul;
    cdb_t        load;
    logic        issue_valid;
    issue_t      issue;
    int          errors;
    int          checks;
    int          cycles = 0;
    logic [16:0] lfsr;
    issue_t      rand_exp [RS_DEPTH];
    int          rand_seen [RS_DEPTH];
    int          rand_issued;

    rs_mul_top u_rs_mul_top (
        .clk             (clk),
        .reset           (reset),
        .disp_valid      (disp_valid),
        .disp_pc         (disp_pc),
        .disp_rd         (disp_rd),
        .disp_src1_tag   (disp_src1.tag),
        .disp_src1_data  (disp_src1.data),
        .disp_src1_valid (disp_src1.valid),
        .disp_src2_tag   (disp_src2.tag),
        .disp_src2_data  (disp_src2.data),
        .disp_src2_valid (disp_src2.valid),
        .alu_valid       (alu.valid),
        .alu_tag         (alu.tag),
        .alu_data        (alu.data),
        .mul_valid       (mul.valid),
        .mul_tag         (mul.tag),
        .mul_data        (mul.data),
        .load_valid      (load.valid),
        .load_tag        (load.tag),
        .load_data       (load.data),
        .issue_valid     (issue_valid),
        .issue_pc        (issue.pc),
        .issue_rd        (issue.rd),
        .issue_src1      (issue.src1),
        .issue_src2      (issue.src2)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run went past %0d cycles without finishing", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // x^17 + x^14 + 1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr[16] ^ lfsr[13];
        lfsr = {lfsr[15:0], fb};
        return fb;
    endfunction

    function automatic data_t rand_word();
        data_t w;
        w = '0;
        for (int i = 0; i < DATA_W; i++) begin
            w = {w[DATA_W-2:0], next_bit()};
        end
        return w;
    endfunction

    function automatic operand_t make_operand(tag_t op_tag, data_t op_data, logic op_valid);
        return '{tag: op_tag, data: op_data, valid: op_valid};
    endfunction

    function automatic issue_t make_issue(pc_t pc, tag_t rd, data_t s1, data_t s2);
        return '{pc: pc, rd: rd, src1: s1, src2: s2};
    endfunction

    // one edge, then drop the strobes
    task automatic step();
        @(posedge clk);
        #1;
        disp_valid = 1'b0;
        alu.valid  = 1'b0;
        mul.valid  = 1'b0;
        load.valid = 1'b0;
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    task automatic drive_dispatch(pc_t pc, tag_t rd, operand_t src1, operand_t src2);
        disp_valid = 1'b1;
        disp_pc    = pc;
        disp_rd    = rd;
        disp_src1  = src1;
        disp_src2  = src2;
    endtask

    task automatic drive_bus(cdb_src_e src, tag_t tag, data_t data);
        case (src)
            CDB_ALU: alu  = '{valid: 1'b1, tag: tag, data: data};
            CDB_MUL: mul  = '{valid: 1'b1, tag: tag, data: data};
            default: load = '{valid: 1'b1, tag: tag, data: data};
        endcase
    endtask

    task automatic check_issue(issue_t exp);
        checks++;
        if (issue_valid !== 1'b1) begin
            errors++;
            $display("** Error at %0t: no issue, expected pc %h rd %h", $time, exp.pc, exp.rd);
        end else if (issue !== exp) begin
            errors++;
            $display("** Error at %0t: issued pc %h rd %h src1 %h src2 %h", $time,
                     issue.pc, issue.rd, issue.src1, issue.src2);
            $display("   expected pc %h rd %h src1 %h src2 %h", exp.pc, exp.rd,
                     exp.src1, exp.src2);
        end
    endtask

    task automatic check_idle();
        checks++;
        if (issue_valid !== 1'b0) begin
            errors++;
            $display("** Error at %0t: unexpected issue of pc %h rd %h", $time,
                     issue.pc, issue.rd);
        end
    endtask

    task automatic take_issue();
        int idx;
        if (issue_valid) begin
            idx = int'(issue.rd) - 60;
            if (idx < 0 || idx >= RS_DEPTH) begin
                errors++;
                $display("** Error at %0t: issue with unknown rd %h", $time, issue.rd);
            end else begin
                check_issue(rand_exp[idx]);
                rand_seen[idx]++;
                rand_issued++;
            end
        end
    endtask

    task automatic test_reset();
        repeat (4) begin
            check_idle();
            step();
        end
    endtask

    task automatic test_direct();
        drive_dispatch(32'h100, 8'd1, make_operand(8'd10, 32'h1234_5678, 1'b1),
                       make_operand(8'd11, 32'h9abc_def0, 1'b1));
        step();
        check_idle();
        step();
        check_issue(make_issue(32'h100, 8'd1, 32'h1234_5678, 32'h9abc_def0));
        step();
        check_idle();
    endtask

    task automatic test_wakeup();
        data_t bus_data;
        for (int b = 0; b < NUM_CDB; b++) begin
            bus_data = data_t'(32'hb000_0000 + b);
            drive_dispatch(pc_t'(32'h200 + 4 * b), tag_t'(2 + b),
                           make_operand(tag_t'(30 + b), 32'hdead_beef, 1'b0),
                           make_operand(8'd40, 32'h0000_4444, 1'b1));
            step();
            repeat (2) begin
                check_idle();
                step();
            end
            drive_bus(cdb_src_e'(b), tag_t'(30 + b), bus_data);
            step();
            check_idle();
            step();
            check_issue(make_issue(pc_t'(32'h200 + 4 * b), tag_t'(2 + b), bus_data,
                                   32'h0000_4444));
        end
    endtask

    task automatic test_bypass();
        drive_bus(CDB_MUL, 8'd45, 32'hcafe_f00d);
        drive_dispatch(32'h300, 8'd5, make_operand(8'd46, 32'h0000_0007, 1'b1),
                       make_operand(8'd45, 32'h0, 1'b0));
        step();
        check_idle();
        step();
        check_issue(make_issue(32'h300, 8'd5, 32'h0000_0007, 32'hcafe_f00d));
        step();
        check_idle();
    endtask

    task automatic test_priority();
        apply_reset();
        for (int i = 0; i < 4; i++) begin
            drive_dispatch(pc_t'(32'h500 + 4 * i), tag_t'(20 + i),
                           make_operand(8'd50, '0, 1'b0), make_operand(8'd70, data_t'(i), 1'b1));
            step();
            check_idle();
        end
        // slot 4 waits on another tag, its wakeup comes one cycle later
        drive_dispatch(32'h510, 8'd24, make_operand(8'd51, '0, 1'b0),
                       make_operand(8'd70, 32'h4, 1'b1));
        drive_bus(CDB_ALU, 8'd50, 32'h5050_5050);
        step();
        check_idle();
        drive_bus(CDB_LOAD, 8'd51, 32'h5151_5151);
        for (int i = 0; i < 4; i++) begin
            step();
            check_issue(make_issue(pc_t'(32'h500 + 4 * i), tag_t'(20 + i), 32'h5050_5050,
                                   data_t'(i)));
        end
        step();
        check_issue(make_issue(32'h510, 8'd24, 32'h5151_5151, 32'h4));
        step();
        check_idle();
    endtask

    task automatic test_random();
        logic  wait1 [RS_DEPTH];
        logic  wait2 [RS_DEPTH];
        data_t d1;
        data_t d2;
        int    guard;
        apply_reset();
        rand_issued = 0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            d1 = rand_word();
            d2 = rand_word();
            wait1[i] = next_bit();
            wait2[i] = next_bit();
            rand_seen[i] = 0;
            rand_exp[i] = make_issue(pc_t'(32'h600 + 4 * i), tag_t'(60 + i), d1, d2);
            drive_dispatch(rand_exp[i].pc, rand_exp[i].rd,
                           make_operand(tag_t'(100 + 2 * i), wait1[i] ? ~d1 : d1, !wait1[i]),
                           make_operand(tag_t'(101 + 2 * i), wait2[i] ? ~d2 : d2, !wait2[i]));
            step();
            take_issue();
        end
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (wait1[i]) begin
                drive_bus(cdb_src_e'(i % NUM_CDB), tag_t'(100 + 2 * i), rand_exp[i].src1);
                step();
                take_issue();
            end
            if (wait2[i]) begin
                drive_bus(cdb_src_e'((i + 1) % NUM_CDB), tag_t'(101 + 2 * i), rand_exp[i].src2);
                step();
                take_issue();
            end
        end
        guard = 0;
        while (rand_issued < RS_DEPTH && guard < 20) begin
            step();
            take_issue();
            guard++;
        end
        step();
        check_idle();
        for (int i = 0; i < RS_DEPTH; i++) begin
            checks++;
            if (rand_seen[i] != 1) begin
                errors++;
                $display("** Error at %0t: instruction %0d issued %0d times instead of once",
                         $time, i, rand_seen[i]);
            end
        end
    endtask

    initial begin
        lfsr       = 17'd81492;
        errors     = 0;
        checks     = 0;
        disp_valid = 1'b0;
        disp_pc    = '0;
        disp_rd    = '0;
        disp_src1  = '0;
        disp_src2  = '0;
        alu        = '0;
        mul        = '0;
        load       = '0;
        apply_reset();
        test_reset();
        test_direct();
        test_wakeup();
        test_bypass();
        test_priority();
        test_random();
        errors += u_rs_mul_top.u_rs_entry_array.u_rs_mul_assert.fails;   // assertion failures
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
verilog/rs_cfg_pkg.sv
verilog/rs_types_pkg.sv
verilog/rs_ifs.sv
verilog/rs_dispatch.sv
verilog/rs_entry_array.sv
verilog/rs_issue_select.sv
verilog/rs_mul_top.sv
bench/rs_mul_assert.sv
bench/rs_mul_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = rs_mul_tb
FILELIST  = tb.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
